// ==== Makefile ====
SIM = verilator
FLAGS = --binary --timing --assert -j 0
TOP = denise_tb
FILELIST = sources.f

OBJ_DIR = obj_dir
BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(filter-out +incdir+%,$(shell cat $(FILELIST))) logic/denise_params.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/collision_detect.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "denise_params.svh"

module collision_detect
	import denise_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire [5:0] bpl_data,
	input wire [`NUM_SPRITES-1:0] spr_valid,
	reg_bus_if.target bus,
	output logic [`DATA_W-1:0] rdata // zero unless clxdat is read
);

	// clx_ctrl fields
	// 15:12 odd sprite enables, 11:6 plane enables, 5:0 plane match values
	logic [`DATA_W-1:0] clx_ctrl;
	logic [14:0] clx_sticky;
	logic [14:0] clx_hit; // collisions in this pixel
	logic [5:0] plane_match;
	logic odd_match; // planes 1, 3, 5
	logic even_match; // planes 2, 4, 6
	logic [3:0] spr_match; // per sprite group
	logic clx_read;

	assign clx_read = bus.read && bus.addr == clxdat;

	always_ff @(posedge clk)
	begin
		if (reset)
			clx_ctrl <= `CLXCON_RESET;
		else if (bus.write && bus.addr == clxcon)
			clx_ctrl <= bus.wdata;
	end

	// --------------------------------------------------
	// match logic

	// a disabled plane always matches
	assign plane_match = ~(bpl_data ^ clx_ctrl[5:0]) | ~clx_ctrl[11:6];
	assign odd_match = plane_match[4] & plane_match[2] & plane_match[0];
	assign even_match = plane_match[5] & plane_match[3] & plane_match[1];

	always_comb
	begin
		for (int g = 0; g < 4; g++)
			spr_match[g] = spr_valid[2*g] | (spr_valid[2*g+1] & clx_ctrl[12+g]);
	end

	always_comb
	begin
		clx_hit[0] = odd_match & even_match; // odd vs even planes
		for (int g = 0; g < 4; g++)
		begin
			clx_hit[1+g] = odd_match & spr_match[g];
			clx_hit[5+g] = even_match & spr_match[g];
		end
		clx_hit[9] = spr_match[0] & spr_match[1]; // sprite vs sprite from here
		clx_hit[10] = spr_match[0] & spr_match[2];
		clx_hit[11] = spr_match[0] & spr_match[3];
		clx_hit[12] = spr_match[1] & spr_match[2];
		clx_hit[13] = spr_match[1] & spr_match[3];
		clx_hit[14] = spr_match[2] & spr_match[3];
	end

	// --------------------------------------------------
	// sticky register, cleared by a clxdat read

	always_ff @(posedge clk)
	begin
		if (reset || clx_read)
			clx_sticky <= '0; // hits in the read cycle are dropped
		else
			clx_sticky <= clx_sticky | clx_hit;
	end

	assign rdata = clx_read ? {1'b1, clx_sticky} : '0; // bit 15 reads as one

endmodule

`default_nettype wire

// ==== logic/color_table.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "denise_params.svh"

module color_table
	import denise_pkg::*;
(
	input wire clk,
	input wire [5:0] select, // bit 5 selects half brite
	reg_bus_if.target bus,
	output rgb_t rgb
);

	localparam int idx_w = $clog2(`NUM_COLORS);
	localparam logic [`ADDR_W-1:0] base_addr = colour_base;

	rgb_t palette [`NUM_COLORS]; // distributed ram, no reset
	rgb_t sel_color;

	// 32-word block at colour_base, low address bits pick the entry
	always_ff @(posedge clk)
	begin
		if (bus.write && bus.addr[`ADDR_W-1:idx_w] == base_addr[`ADDR_W-1:idx_w])
			palette[bus.addr[idx_w-1:0]] <= rgb_t'(bus.wdata[`RGB_W-1:0]);
	end

	assign sel_color = palette[select[idx_w-1:0]]; // async read

	// extra half brite
	always_comb
	begin
		rgb = sel_color;
		if (select[idx_w])
		begin
			rgb.red = sel_color.red >> 1; // each gun halved
			rgb.green = sel_color.green >> 1;
			rgb.blue = sel_color.blue >> 1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/denise_params.svh ====
`ifndef DENISE_PARAMS_SVH
`define DENISE_PARAMS_SVH

// --------------------------------------------------
// widths

`define RGB_W 12 // three 4-bit guns
`define ADDR_W 8 // register word address
`define DATA_W 16

// bus master parks here when no register is accessed
`define IDLE_ADDR {`ADDR_W{1'b1}}

// --------------------------------------------------
// table sizes

`define NUM_COLORS 32
`define NUM_HAM_COLORS 16 // shadows the first half of the colour table
`define NUM_SPRITES 8

// collision control after reset
// all planes enabled with match value one, all odd sprites enabled
`define CLXCON_RESET 16'hffff

`endif

// ==== logic/denise_pkg.sv ====
`default_nettype none
`include "denise_params.svh"

package denise_pkg;

	// register word addresses (byte address shifted right by one)
	typedef enum logic [`ADDR_W-1:0] {
		clxdat = 8'h07, // collision data, only readable register
		diwstrt = 8'h47, // window start, vertical in 15:8
		diwstop = 8'h48, // window stop
		clxcon = 8'h4c, // collision control
		bplcon0 = 8'h80, // bit 11 is HAM
		bplcon2 = 8'h82, // sprite vs playfield priority
		colour_base = 8'hc0 // 32 colour registers from here
	} reg_addr_e;

	// top two bitplane bits in HAM mode
	typedef enum logic [1:0] {
		ham_load = 2'b00, // take palette entry
		ham_mod_blue = 2'b01,
		ham_mod_red = 2'b10,
		ham_mod_green = 2'b11
	} ham_op_e;

	typedef struct packed {
		logic [`RGB_W/3-1:0] red;
		logic [`RGB_W/3-1:0] green;
		logic [`RGB_W/3-1:0] blue;
	} rgb_t;

endpackage

`default_nettype wire

// ==== logic/denise_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "denise_params.svh"

module denise_top
	import denise_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire sol,
	input wire sof,
	input wire [`ADDR_W-1:0] reg_addr,
	input wire [`DATA_W-1:0] reg_wdata,
	input wire reg_write,
	input wire reg_read,
	input wire [5:0] bpl_data, // playfield colour index
	input wire [`NUM_SPRITES-1:0] spr_valid,
	input wire [3:0] spr_color, // index into colours 16..31
	input wire blank,
	output logic [`DATA_W-1:0] reg_rdata,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue
);

	reg_bus_if bus ();

	logic ham_mode; // bplcon0 bit 11
	logic [5:0] pri_ctrl; // bplcon2, pf2 in 5:3, pf1 in 2:0
	logic window;
	logic spr_select;
	logic spr_select_d; // delay stage
	logic [5:0] pf_data_d;
	logic [3:0] spr_color_d;
	logic [5:0] table_sel;
	rgb_t table_rgb;
	rgb_t ham_rgb;
	rgb_t mux_rgb;
	rgb_t out_rgb; // output register

	assign bus.addr = reg_addr;
	assign bus.wdata = reg_wdata;
	assign bus.write = reg_write;
	assign bus.read = reg_read;

	// --------------------------------------------------
	// control registers

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ham_mode <= 1'b0;
			pri_ctrl <= '0;
		end
		else if (bus.write)
		begin
			if (bus.addr == bplcon0)
				ham_mode <= bus.wdata[11];
			if (bus.addr == bplcon2)
				pri_ctrl <= bus.wdata[5:0];
		end
	end

	display_window i_display_window (.clk, .sol, .sof, .bus(bus.target), .window);

	sprite_priority i_sprite_priority (
		.spr_valid,
		.pf1_pri(pri_ctrl[2:0]),
		.pf2_pri(pri_ctrl[5:3]),
		.pf_valid({1'b0, |bpl_data}), // single playfield, colour 0 is transparent
		.spr_select
	);

	color_table i_color_table (.clk, .select(table_sel), .bus(bus.target), .rgb(table_rgb));

	ham_generator i_ham_generator (.clk, .bpl_data, .bus(bus.target), .rgb(ham_rgb));

	collision_detect i_collision_detect (
		.clk,
		.reset,
		.bpl_data,
		.spr_valid,
		.bus(bus.target),
		.rdata(reg_rdata)
	);

	// one pixel delay, lines up with the HAM hold register
	always_ff @(posedge clk)
	begin
		spr_select_d <= spr_select;
		pf_data_d <= bpl_data;
		spr_color_d <= spr_color;
	end

	// --------------------------------------------------
	// colour multiplexers

	always_comb
	begin
		if (!window)
			table_sel = 6'd0; // border colour
		else if (ham_mode || spr_select_d)
			table_sel = {2'b01, spr_color_d};
		else
			table_sel = pf_data_d;
	end

	// HAM colour only for playfield pixels inside the window
	assign mux_rgb = (ham_mode && window && !spr_select_d) ? ham_rgb : table_rgb;

	always_ff @(posedge clk)
	begin
		if (blank)
			out_rgb <= '0;
		else
			out_rgb <= mux_rgb;
	end

	assign red = out_rgb.red;
	assign green = out_rgb.green;
	assign blue = out_rgb.blue;

endmodule

`default_nettype wire

// ==== logic/display_window.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "denise_params.svh"

module display_window
	import denise_pkg::*;
(
	input wire clk,
	input wire sol, // start of line
	input wire sof, // start of frame
	reg_bus_if.target bus,
	output logic window // beam inside display window
);

	logic [`DATA_W-1:0] diw_start; // vstart 15:8, hstart 7:0
	logic [`DATA_W-1:0] diw_stop; // vstop 15:8, hstop 7:0
	logic [8:0] hpos; // local beam counters
	logic [8:0] vpos;
	logic h_win;
	logic v_win;

	// --------------------------------------------------
	// window position registers

	always_ff @(posedge clk)
	begin
		if (bus.write && bus.addr == diwstrt)
			diw_start <= bus.wdata;
		if (bus.write && bus.addr == diwstop)
			diw_stop <= bus.wdata;
	end

	// --------------------------------------------------
	// beam counters, synced by sol and sof

	always_ff @(posedge clk)
	begin
		if (sol)
			hpos <= '0;
		else
			hpos <= hpos + 9'd1; // one lores pixel per clock
	end

	always_ff @(posedge clk)
	begin
		if (sof)
			vpos <= '0;
		else if (sol)
			vpos <= vpos + 9'd1;
	end

	// --------------------------------------------------
	// window flags, one edge behind the counter match

	always_ff @(posedge clk)
	begin
		if (hpos == {1'b0, diw_start[7:0]}) // start always in left half
			h_win <= 1'b1;
		else if (hpos == {1'b1, diw_stop[7:0]}) // stop always in right half
			h_win <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (vpos == {1'b0, diw_start[15:8]})
			v_win <= 1'b1;
		// stop row bit 8 is the inverse of bit 7
		else if (vpos == {~diw_stop[15], diw_stop[15:8]})
			v_win <= 1'b0;
	end

	assign window = h_win & v_win;

endmodule

`default_nettype wire

// ==== logic/ham_generator.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "denise_params.svh"

module ham_generator
	import denise_pkg::*;
(
	input wire clk,
	input wire [5:0] bpl_data, // op in 5:4, value in 3:0
	reg_bus_if.target bus,
	output rgb_t rgb
);

	localparam int idx_w = $clog2(`NUM_HAM_COLORS);
	localparam logic [`ADDR_W-1:0] base_addr = colour_base;

	// private copy of colours 0..15 so sprites keep the full table
	rgb_t ham_palette [`NUM_HAM_COLORS];
	rgb_t ham_color;
	rgb_t hold_rgb; // last pixel colour
	ham_op_e ham_op;
	logic [idx_w-1:0] mod_val;

	always_ff @(posedge clk)
	begin
		if (bus.write && bus.addr[`ADDR_W-1:idx_w] == base_addr[`ADDR_W-1:idx_w])
			ham_palette[bus.addr[idx_w-1:0]] <= rgb_t'(bus.wdata[`RGB_W-1:0]);
	end

	assign ham_op = ham_op_e'(bpl_data[5:4]);
	assign mod_val = bpl_data[idx_w-1:0];
	assign ham_color = ham_palette[mod_val];

	// --------------------------------------------------
	// hold and modify, same edge as the top level delay stage

	always_ff @(posedge clk)
	begin
		case (ham_op)
			ham_load: hold_rgb <= ham_color;
			ham_mod_blue: hold_rgb.blue <= mod_val; // red, green held
			ham_mod_red: hold_rgb.red <= mod_val;
			ham_mod_green: hold_rgb.green <= mod_val;
			default: hold_rgb <= hold_rgb;
		endcase
	end

	assign rgb = hold_rgb;

endmodule

`default_nettype wire

// ==== logic/reg_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "denise_params.svh"

// strobe style register bus, one access per cycle, no wait states
interface reg_bus_if;

	logic [`ADDR_W-1:0] addr; // word address
	logic [`DATA_W-1:0] wdata;
	logic write; // data lands at this edge
	logic read; // clxdat read also clears the sticky bits

	// top level drives everything
	modport master (output addr, wdata, write, read);

	// register owners only listen, each decodes its own addresses
	modport target (input addr, wdata, write, read);

endinterface

`default_nettype wire

// ==== logic/sprite_priority.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "denise_params.svh"

module sprite_priority (
	input wire [`NUM_SPRITES-1:0] spr_valid, // per sprite pixel valid
	input wire [2:0] pf1_pri, // bplcon2 2:0
	input wire [2:0] pf2_pri, // bplcon2 5:3
	input wire [1:0] pf_valid, // bit 0 playfield 1, bit 1 playfield 2
	output logic spr_select // sprite pixel goes out
);

	localparam int num_groups = `NUM_SPRITES / 2;

	logic [num_groups-1:0] spr_group; // sprites paired 0/1, 2/3 ...
	logic [2:0] spr_code; // 1..4 frontmost group, 7 for none
	logic pf1_front;
	logic pf2_front;

	always_comb
	begin
		for (int i = 0; i < num_groups; i++)
			spr_group[i] = |spr_valid[2*i +: 2];
	end

	// priority encoder, lowest group is in front
	always_comb
	begin
		spr_code = 3'd7;
		for (int i = num_groups - 1; i >= 0; i--)
		begin
			if (spr_group[i])
				spr_code = 3'(i + 1);
		end
	end

	// playfield in front when its priority is below the group code
	assign pf1_front = spr_code > pf1_pri;
	assign pf2_front = spr_code > pf2_pri;

	always_comb
	begin
		if (spr_code == 3'd7)
			spr_select = 1'b0; // nothing to show
		else if (pf1_front && pf_valid[0])
			spr_select = 1'b0;
		else if (pf2_front && pf_valid[1])
			spr_select = 1'b0;
		else
			spr_select = 1'b1;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+logic
logic/denise_pkg.sv
logic/reg_bus_if.sv
logic/display_window.sv
logic/color_table.sv
logic/ham_generator.sv
logic/sprite_priority.sv
logic/collision_detect.sv
logic/denise_top.sv
tests/denise_properties.sv
tests/denise_tb.sv

// ==== tests/denise_properties.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "denise_params.svh"

module denise_properties
	import denise_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire blank,
	input wire reg_read,
	input wire [`ADDR_W-1:0] reg_addr,
	input wire [`DATA_W-1:0] reg_rdata,
	input wire [5:0] bpl_data,
	input wire [`NUM_SPRITES-1:0] spr_valid,
	input wire spr_select, // internal to the top level
	input wire [3:0] red,
	input wire [3:0] green,
	input wire [3:0] blue
);

	// blank at one edge means black right after it
	blank_zeroes_output: assert property (@(posedge clk) disable iff (reset)
		blank |=> (red == 4'd0 && green == 4'd0 && blue == 4'd0))
		else $error("outputs not black one edge after blank");

	// bit 15 always set, a read right behind a read sees the cleared sticky bits
	clxdat_read_value: assert property (@(posedge clk) disable iff (reset)
		(reg_read && reg_addr == clxdat) |-> (reg_rdata[15] &&
		(!$past(reg_read && reg_addr == clxdat) || reg_rdata[14:0] == 15'd0)))
		else $error("collision read without bit 15 set or sticky bits not cleared");

	// no sprite pixel, nothing to select
	// transparent playfield, any valid sprite shows
	no_sprite_no_select: assert property (@(posedge clk) disable iff (reset)
		(spr_valid == '0 || bpl_data == 6'd0) |-> (spr_select == (spr_valid != '0)))
		else $error("sprite select wrong with no sprite or no playfield data");

endmodule

bind denise_top denise_properties i_denise_properties (
	.clk,
	.reset,
	.blank,
	.reg_read,
	.reg_addr,
	.reg_rdata,
	.bpl_data,
	.spr_valid,
	.spr_select,
	.red,
	.green,
	.blue
);

`default_nettype wire

// ==== tests/denise_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "denise_params.svh"

module denise_tb
	import denise_pkg::*;
();

	localparam int num_pix = 200; // pixels per random stream
	// seven streams, palette load, window sweep and some slack
	localparam int test_cycles = 7 * num_pix + 300;

	logic clk;
	logic reset;
	logic sol;
	logic sof;
	logic [`ADDR_W-1:0] reg_addr;
	logic [`DATA_W-1:0] reg_wdata;
	logic reg_write;
	logic reg_read;
	logic [`DATA_W-1:0] reg_rdata;
	logic [5:0] bpl_data;
	logic [`NUM_SPRITES-1:0] spr_valid;
	logic [3:0] spr_color;
	logic blank;
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;

	// reference model state
	logic [`RGB_W-1:0] pal_m [`NUM_COLORS];
	logic ham_m;
	logic [2:0] pri_m; // playfield 1 priority
	logic win_m; // window fully open or fully closed
	logic [`RGB_W-1:0] ham_hold_m;
	logic sof_level;
	logic [31:0] rng;
	int errors;
	logic [`RGB_W-1:0] exp_q [$]; // one entry per clock
	bit chk_q [$];
	logic [`RGB_W-1:0] exp_now;
	bit chk_now;
	logic [`DATA_W-1:0] clx_val;

	denise_top i_denise_top (
		.clk,
		.reset,
		.sol,
		.sof,
		.reg_addr,
		.reg_wdata,
		.reg_write,
		.reg_read,
		.bpl_data,
		.spr_valid,
		.spr_color,
		.blank,
		.reg_rdata,
		.red,
		.green,
		.blue
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns pixel clock
	end

	// --------------------------------------------------
	// reference model

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// hold and modify on the first 16 colours
	function automatic logic [`RGB_W-1:0] ham_next(input logic [`RGB_W-1:0] hold,
		input logic [5:0] bpl);
		case (bpl[5:4])
			2'b00: return pal_m[{1'b0, bpl[3:0]}];
			2'b01: return {hold[11:4], bpl[3:0]}; // new blue
			2'b10: return {bpl[3:0], hold[7:0]}; // new red
			default: return {hold[11:8], bpl[3:0], hold[3:0]}; // new green
		endcase
	endfunction

	function automatic logic [`RGB_W-1:0] expected_rgb(input logic [5:0] bpl,
		input logic [7:0] sv, input logic [3:0] sc);
		logic [2:0] group;
		logic sprite_wins;
		logic [5:0] sel;
		logic [`RGB_W-1:0] col;
		// frontmost sprite pair, 0 for none
		if (sv[1:0] != 2'b00)
			group = 3'd1;
		else if (sv[3:2] != 2'b00)
			group = 3'd2;
		else if (sv[5:4] != 2'b00)
			group = 3'd3;
		else if (sv[7:6] != 2'b00)
			group = 3'd4;
		else
			group = 3'd0;
		// playfield beats the sprite only with data and a lower priority value
		sprite_wins = group != 3'd0 && (bpl == 6'd0 || group <= pri_m);
		if (!win_m)
			sel = 6'd0; // border
		else if (ham_m || sprite_wins)
			sel = {2'b01, sc}; // sprite colours in 16..31
		else
			sel = bpl;
		col = pal_m[sel[4:0]];
		if (sel[5])
			col = {1'b0, col[11:9], 1'b0, col[7:5], 1'b0, col[3:1]}; // half brite
		if (ham_m && win_m && !sprite_wins)
			col = ham_hold_m;
		return col;
	endfunction

	// --------------------------------------------------
	// stimulus

	task automatic stop_on_error(input string msg);
		errors++;
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// one clock of stimulus, every cycle goes through here
	task automatic step(input logic [5:0] bpl, input logic [7:0] sv, input logic [3:0] sc,
		input logic blk, input logic wr, input logic rd, input logic [7:0] addr,
		input logic [15:0] wdata, input bit chk);
		@(posedge clk);
		#1;
		bpl_data = bpl;
		spr_valid = sv;
		spr_color = sc;
		blank = blk;
		reg_write = wr;
		reg_read = rd;
		reg_addr = addr;
		reg_wdata = wdata;
		sof = sof_level;
		if (blk && exp_q.size() > 0)
			exp_q[exp_q.size()-1] = '0; // blank hits the pixel one cycle ahead
		ham_hold_m = ham_next(ham_hold_m, bpl);
		exp_q.push_back(expected_rgb(bpl, sv, sc));
		chk_q.push_back(chk);
	endtask

	task automatic idle(input int n);
		repeat (n)
			step(6'd0, 8'd0, 4'd0, 1'b0, 1'b0, 1'b0, `IDLE_ADDR, 16'd0, 1'b0);
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [15:0] data);
		if (addr >= colour_base && addr <= colour_base + 8'd31)
			pal_m[5'(addr - colour_base)] = data[11:0];
		if (addr == bplcon0)
			ham_m = data[11];
		if (addr == bplcon2)
			pri_m = data[2:0];
		step(6'd0, 8'd0, 4'd0, 1'b0, 1'b1, 1'b0, addr, data, 1'b0);
	endtask

	task automatic read_clx(output logic [15:0] data);
		step(6'd0, 8'd0, 4'd0, 1'b0, 1'b0, 1'b1, clxdat, 16'd0, 1'b0);
		@(negedge clk);
		data = reg_rdata; // combinational, same cycle
	endtask

	task automatic random_pixels(input int n, input bit with_sprites, input bit with_blank);
		logic [7:0] sv;
		logic blk;
		repeat (n)
		begin
			rng = xorshift(rng);
			sv = with_sprites ? (rng[15:8] & rng[23:16] & rng[31:24]) : 8'd0; // sparse
			blk = with_blank ? rng[28] : 1'b0;
			step(rng[5:0], sv, rng[27:24], blk, 1'b0, 1'b0, `IDLE_ADDR, 16'd0, 1'b1);
		end
	endtask

	// --------------------------------------------------
	// compare, two edges after each pixel

	always @(negedge clk)
	begin
		if (exp_q.size() == 3)
		begin
			exp_now = exp_q.pop_front();
			chk_now = chk_q.pop_front();
			if (chk_now)
				assert ({red, green, blue} == exp_now)
				else stop_on_error($sformatf("mismatch at %0t: rgb %h, expected %h",
					$time, {red, green, blue}, exp_now));
		end
	end

	initial
	begin
		#(test_cycles * 8 + 800);
		$display("watchdog expired before the tests finished");
		$display("TESTS FAILED");
		$fatal(1, "timeout");
	end

	initial
	begin
		errors = 0;
		rng = 32'd93;
		reset = 1'b1;
		sol = 1'b1; // horizontal counter parked at 0
		sof = 1'b1;
		sof_level = 1'b1;
		reg_addr = `IDLE_ADDR;
		reg_wdata = '0;
		reg_write = 1'b0;
		reg_read = 1'b0;
		bpl_data = '0;
		spr_valid = '0;
		spr_color = '0;
		blank = 1'b0;
		win_m = 1'b0;
		ham_m = 1'b0;
		pri_m = 3'd0;
		ham_hold_m = '0;
		for (int i = 0; i < `NUM_COLORS; i++)
			pal_m[i] = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// collisions first, while the sticky bits are still clean
		step(6'h15, 8'h01, 4'd0, 1'b0, 1'b0, 1'b0, `IDLE_ADDR, 16'd0, 1'b0);
		read_clx(clx_val);
		assert (clx_val == 16'h8002) // odd planes vs sprite pair 0
		else stop_on_error($sformatf("mismatch at %0t: clxdat %h, expected 8002",
			$time, clx_val));
		read_clx(clx_val);
		assert (clx_val == 16'h8000)
		else stop_on_error($sformatf("mismatch at %0t: clxdat %h, expected 8000",
			$time, clx_val));

		for (int i = 0; i < `NUM_COLORS; i++)
		begin
			rng = xorshift(rng);
			write_reg(colour_base + 8'(i), rng[15:0]);
		end

		// window fully open, start at 0 on both counters
		write_reg(diwstrt, 16'h0000);
		write_reg(diwstop, 16'h0000);
		idle(4);
		win_m = 1'b1;
		random_pixels(num_pix, 1'b0, 1'b0); // includes half brite indexes

		// sprites behind, between and in front of playfield 1
		for (int p = 0; p <= 4; p += 2)
		begin
			write_reg(bplcon2, 16'(p));
			idle(2);
			random_pixels(num_pix, 1'b1, 1'b0);
		end

		write_reg(bplcon0, 16'h0800); // HAM on
		idle(2);
		random_pixels(num_pix, 1'b1, 1'b0);
		write_reg(bplcon0, 16'h0000);

		random_pixels(num_pix, 1'b1, 1'b1); // random blank

		// -------------------------------------------------
		// close the window, sweep the vertical counter past row 1 and row 128
		write_reg(diwstrt, 16'h0100);
		write_reg(diwstop, 16'h8000);
		sof_level = 1'b0;
		idle(140);
		sof_level = 1'b1;
		idle(4);
		win_m = 1'b0;
		random_pixels(num_pix, 1'b1, 1'b0); // border everywhere

		idle(3); // drain
		if (errors == 0)
		begin
			$display("TESTS PASSED");
			$finish;
		end
		else
		begin
			$display("TESTS FAILED");
			$fatal(1, "errors found");
		end
	end

endmodule

`default_nettype wire
